// File: msg_pkg.sv
package msg_pkg;

  localparam int XB_SIZE = 32; // PC message width

  // low two bits of every message
  typedef enum logic [1:0] {
    MSG_PIX       = 2'd0, // pixel sample
    MSG_COEFF_END = 2'd1  // closes the coefficient stream
  } msg_kind_t;

  // camera sample as it arrives from the PC with msb first
  typedef struct packed {
    logic [19:0] fds;     // sample value with the 4 lsbs dropped upstream
    logic [5:0]  rsvd_hi;
    logic        fval;    // frame valid
    logic        lval;    // line valid
    logic [1:0]  rsvd_lo;
    msg_kind_t   kind;
  } pixel_msg_t;

  // same word seen either as a pixel or as a raw coefficient fragment
  typedef union packed {
    pixel_msg_t           pix;
    logic [XB_SIZE-1:0]   raw;
  } msg_word_u;

  typedef enum logic [1:0] {
    PIX_STANDBY,
    PIX_INTRALINE,
    PIX_INTERLINE,
    PIX_INTERFRAME
  } pixel_state_t;

  typedef struct packed {
    logic [10:0] col;   // up to 2048 columns
    logic [11:0] row;   // 2k rows plus dark rows top and bottom
    logic [19:0] frame;
    logic [19:0] fds;   // sample of the latest popped word
  } pixel_pos_t;

endpackage

// File: dram_pkg.sv
package dram_pkg;
  import msg_pkg::*;

  localparam int ADDR_WIDTH     = 27;
  localparam int APP_DATA_WIDTH = 256;

  // one BL8 burst is two controller beats
  localparam int MSGS_PER_BURST = 2 * APP_DATA_WIDTH / XB_SIZE;

  localparam logic [ADDR_WIDTH-1:0] START_ADDR = '0;
  localparam logic [ADDR_WIDTH-1:0] ADDR_INC   = 27'd8; // BL8

  typedef struct packed {
    logic                  en;   // app_en
    logic                  read; // command is a read
    logic [ADDR_WIDTH-1:0] addr;
  } dram_req_t;

  typedef enum logic [2:0] {
    DRAMIFC_ERROR,
    DRAMIFC_MSG_WAIT,
    DRAMIFC_WR_WAIT,
    DRAMIFC_WR1,
    DRAMIFC_WR2,
    DRAMIFC_READING,
    DRAMIFC_THROTTLED,
    DRAMIFC_INTERFRAME
  } dramifc_state_t;

endpackage

// File: msg_fifo.sv
module msg_fifo import msg_pkg::*; #(
  parameter int FIFO_DEPTH = 16
) (
  input  logic      bus_clk,
  input  logic      fds_val,
  input  msg_word_u din,
  input  logic      wr_en,
  input  logic      rd_en,
  output msg_word_u dout,
  output logic      empty,
  output logic      almost_full
);
  localparam int AW = $clog2(FIFO_DEPTH);

  msg_word_u mem [FIFO_DEPTH];
  logic [AW-1:0] wr_ptr, rd_ptr;
  logic [$clog2(FIFO_DEPTH+1)-1:0] count;
  logic wr_ok, rd_ok;

  assign empty       = count == 0;
  assign almost_full = count >= FIFO_DEPTH - 2; // room left for the router's late write
  assign wr_ok       = wr_en && count != FIFO_DEPTH;
  assign rd_ok       = rd_en && !empty;
  assign dout        = mem[rd_ptr]; // show-ahead

  always_ff @(posedge bus_clk) begin
    if (wr_ok) mem[wr_ptr] <= din;
  end

  always_ff @(posedge bus_clk or posedge fds_val) begin
    if (fds_val) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_ok) wr_ptr <= (wr_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (rd_ok) rd_ptr <= (rd_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({wr_ok, rd_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: pc_msg_router.sv
module pc_msg_router import msg_pkg::*; (
  input  logic      bus_clk,
  input  logic      fds_val,
  input  msg_word_u pc_msg,
  input  logic      pc_msg_empty,
  output logic      pc_msg_ack,
  input  logic      pix_full,
  input  logic      dram_full,
  output msg_word_u msg_d,
  output logic      pix_wren,
  output logic      dram_wren
);
  logic [3:0] n_dram_msg; // wraps every 16 words to mark one DRAM group
  logic       is_pix;
  logic       is_pix_d;
  logic       pending_d;

  assign pc_msg_ack = !(pc_msg_empty || pix_full || dram_full);

  // a kind 0 word is a pixel only outside a coefficient group
  assign is_pix = pc_msg.pix.kind == MSG_PIX && n_dram_msg == 4'd0;

  assign pix_wren  = pending_d &&  is_pix_d && !pix_full;
  assign dram_wren = pending_d && !is_pix_d && !dram_full;

  always_ff @(posedge bus_clk) begin
    if (pc_msg_ack) msg_d <= pc_msg; // lines up with pending_d
  end

  always_ff @(posedge bus_clk or posedge fds_val) begin
    if (fds_val) begin
      n_dram_msg <= '0;
      is_pix_d   <= 1'b0;
      pending_d  <= 1'b0;
    end else begin
      pending_d <= pc_msg_ack;
      if (pc_msg_ack) begin
        is_pix_d <= is_pix;
        if (!is_pix) n_dram_msg <= n_dram_msg + 1'b1;
      end
    end
  end

endmodule

// File: pixel_tracker.sv
module pixel_tracker import msg_pkg::*; #(
  parameter int HB_CTR_SIZE = 16
) (
  input  logic       bus_clk,
  input  logic       fds_val,
  input  msg_word_u  pix_msg,
  input  logic       pix_empty,
  output logic       pix_ack,
  output pixel_pos_t pos,
  output logic       frame_start,
  output logic       heartbeat
);
  pixel_state_t state;
  logic [HB_CTR_SIZE-1:0] hb_ctr;
  logic fval, lval;

  // FIFO is show-ahead, so pop as soon as a word shows up
  assign pix_ack   = !pix_empty;
  assign fval      = pix_msg.pix.fval;
  assign lval      = pix_msg.pix.lval;
  assign heartbeat = hb_ctr[HB_CTR_SIZE-1];

  always_ff @(posedge bus_clk or posedge fds_val) begin
    if (fds_val) begin
      state       <= PIX_STANDBY;
      pos         <= '0;
      hb_ctr      <= '0;
      frame_start <= 1'b0;
    end else begin
      frame_start <= 1'b0;
      if (pix_ack) begin
        hb_ctr  <= hb_ctr + 1'b1;
        pos.fds <= pix_msg.pix.fds;
        case (state)
          PIX_STANDBY:
            if (!fval) begin // sync up on a frame gap
              pos.col   <= '0;
              pos.row   <= '0;
              pos.frame <= '0;
              state     <= PIX_INTERFRAME;
            end
          PIX_INTRALINE:
            if (lval) begin
              pos.col <= pos.col + 1'b1;
            end else if (fval) begin
              pos.row <= pos.row + 1'b1; // end of line
              state   <= PIX_INTERLINE;
            end else begin
              pos.frame <= pos.frame + 1'b1; // end of frame
              state     <= PIX_INTERFRAME;
            end
          PIX_INTERLINE:
            if (lval) begin
              pos.col <= '0;
              state   <= PIX_INTRALINE;
            end
          PIX_INTERFRAME:
            if (lval) begin
              pos.col     <= '0;
              pos.row     <= '0;
              frame_start <= 1'b1; // kicks off the coefficient replay
              state       <= PIX_INTRALINE;
            end
          default: state <= PIX_STANDBY;
        endcase
      end
    end
  end

endmodule

// File: coeff_packer.sv
module coeff_packer import msg_pkg::*, dram_pkg::*; (
  input  logic                        bus_clk,
  input  logic                        fds_val,
  input  msg_word_u                   dram_msg,
  input  logic                        dram_empty,
  output logic                        dram_ack,
  output logic                        burst_valid,
  output logic                        burst_last,
  output logic [2*APP_DATA_WIDTH-1:0] burst_data,
  input  logic                        burst_taken
);
  // wraps back to 0 after the closing fragment
  logic [$clog2(MSGS_PER_BURST)-1:0] frag_idx;

  assign dram_ack = !dram_empty && !burst_valid;

  always_ff @(posedge bus_clk) begin
    if (dram_ack) burst_data[frag_idx*XB_SIZE +: XB_SIZE] <= dram_msg.raw; // fragment 0 lowest
  end

  always_ff @(posedge bus_clk or posedge fds_val) begin
    if (fds_val) begin
      frag_idx    <= '0;
      burst_valid <= 1'b0;
      burst_last  <= 1'b0;
    end else begin
      if (dram_ack) begin
        frag_idx <= frag_idx + 1'b1;
        if (frag_idx == $bits(frag_idx)'(MSGS_PER_BURST - 1)) begin
          burst_valid <= 1'b1;
          burst_last  <= dram_msg.pix.kind == MSG_COEFF_END;
        end
      end else if (burst_taken) begin
        burst_valid <= 1'b0; // sequencer has both beats
      end
    end
  end

endmodule

// File: dram_sequencer.sv
module dram_sequencer import dram_pkg::*; (
  input  logic                        bus_clk,
  input  logic                        fds_val,
  input  logic                        burst_valid,
  input  logic                        burst_last,
  input  logic [2*APP_DATA_WIDTH-1:0] burst_data,
  output logic                        burst_taken,
  input  logic                        app_rdy,
  input  logic                        app_wdf_rdy,
  input  logic                        coeff_high,
  input  logic                        frame_start,
  output dram_req_t                   req,
  output logic                        app_wdf_wren,
  output logic                        app_wdf_end,
  output logic [APP_DATA_WIDTH-1:0]   app_wdf_data,
  output logic                        error
);
  dramifc_state_t state;
  logic [ADDR_WIDTH-1:0] end_addr; // one past the last written burst
  logic [ADDR_WIDTH-1:0] next_addr;

  assign next_addr   = req.addr + ADDR_INC;
  assign burst_taken = state == DRAMIFC_WR2;
  assign error       = state == DRAMIFC_ERROR;

  always_ff @(posedge bus_clk) begin
    if (state == DRAMIFC_WR_WAIT && app_rdy && app_wdf_rdy)
      app_wdf_data <= burst_data[0 +: APP_DATA_WIDTH];
    else if (state == DRAMIFC_WR1 && app_wdf_rdy)
      app_wdf_data <= burst_data[APP_DATA_WIDTH +: APP_DATA_WIDTH];
  end

  always_ff @(posedge bus_clk or posedge fds_val) begin
    if (fds_val) begin
      state        <= DRAMIFC_MSG_WAIT;
      req          <= '{en: 1'b0, read: 1'b0, addr: START_ADDR};
      end_addr     <= START_ADDR;
      app_wdf_wren <= 1'b0;
      app_wdf_end  <= 1'b1;
    end else begin
      case (state)
        DRAMIFC_ERROR: ; // stuck until reset
        DRAMIFC_MSG_WAIT:
          if (burst_valid) begin
            req.en <= 1'b1; // write command for the held burst
            state  <= DRAMIFC_WR_WAIT;
          end
        DRAMIFC_WR_WAIT:
          if (app_rdy && app_wdf_rdy) begin
            req.en       <= 1'b0;
            app_wdf_wren <= 1'b1;
            app_wdf_end  <= 1'b0; // beat 0
            state        <= DRAMIFC_WR1;
          end
        DRAMIFC_WR1:
          if (app_wdf_rdy) begin
            app_wdf_end <= 1'b1; // beat 1
            state       <= DRAMIFC_WR2;
          end
        DRAMIFC_WR2: begin
          app_wdf_wren <= 1'b0;
          req.addr     <= next_addr;
          if (!app_wdf_rdy) begin
            state <= DRAMIFC_ERROR; // controller dropped beat 1
          end else if (burst_last) begin
            end_addr <= next_addr;
            req      <= '{en: 1'b1, read: 1'b1, addr: START_ADDR};
            state    <= DRAMIFC_READING;
          end else begin
            state <= DRAMIFC_MSG_WAIT;
          end
        end
        DRAMIFC_READING: begin
          if (app_rdy) req.addr <= next_addr;
          if (app_rdy && next_addr == end_addr) begin
            req.en <= 1'b0; // whole range issued
            state  <= DRAMIFC_INTERFRAME;
          end else if (coeff_high) begin
            req.en <= 1'b0; // address already advanced if accepted
            state  <= DRAMIFC_THROTTLED;
          end
        end
        DRAMIFC_THROTTLED:
          if (!coeff_high) begin
            req.en <= 1'b1;
            state  <= DRAMIFC_READING;
          end
        DRAMIFC_INTERFRAME:
          if (frame_start) begin
            req.addr <= START_ADDR; // replay for the new frame
            req.en   <= 1'b1;
            state    <= DRAMIFC_READING;
          end
        default: state <= DRAMIFC_ERROR;
      endcase
    end
  end

endmodule

// File: application.sv
module application import msg_pkg::*, dram_pkg::*; #(
  parameter int FIFO_DEPTH  = 16,
  parameter int HB_CTR_SIZE = 16
) (
  input  logic                      bus_clk,
  input  logic                      fds_val,
  input  msg_word_u                 pc_msg,
  input  logic                      pc_msg_empty,
  output logic                      pc_msg_ack,
  input  logic                      app_rdy,
  input  logic                      app_wdf_rdy,
  input  logic                      coeff_high,
  output dram_req_t                 req,
  output logic                      app_wdf_wren,
  output logic                      app_wdf_end,
  output logic [APP_DATA_WIDTH-1:0] app_wdf_data,
  output pixel_pos_t                pos,
  output logic                      heartbeat,
  output logic                      error
);
  msg_word_u msg_d, pix_msg, dram_msg;
  logic pix_wren, dram_wren, pix_full, dram_full;
  logic pix_empty, dram_empty, pix_ack, dram_ack;
  logic frame_start;
  logic burst_valid, burst_last, burst_taken;
  logic [2*APP_DATA_WIDTH-1:0] burst_data;

  pc_msg_router router_inst (
    .bus_clk, .fds_val, .pc_msg, .pc_msg_empty, .pc_msg_ack,
    .pix_full, .dram_full, .msg_d, .pix_wren, .dram_wren
  );

  msg_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) pix_fifo (
    .bus_clk, .fds_val, .din(msg_d), .wr_en(pix_wren), .rd_en(pix_ack),
    .dout(pix_msg), .empty(pix_empty), .almost_full(pix_full)
  );

  msg_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) dram_fifo (
    .bus_clk, .fds_val, .din(msg_d), .wr_en(dram_wren), .rd_en(dram_ack),
    .dout(dram_msg), .empty(dram_empty), .almost_full(dram_full)
  );

  pixel_tracker #(.HB_CTR_SIZE(HB_CTR_SIZE)) tracker_inst (
    .bus_clk, .fds_val, .pix_msg, .pix_empty, .pix_ack,
    .pos, .frame_start, .heartbeat
  );

  coeff_packer packer_inst (
    .bus_clk, .fds_val, .dram_msg, .dram_empty, .dram_ack,
    .burst_valid, .burst_last, .burst_data, .burst_taken
  );

  dram_sequencer sequencer_inst (
    .bus_clk, .fds_val, .burst_valid, .burst_last, .burst_data, .burst_taken,
    .app_rdy, .app_wdf_rdy, .coeff_high, .frame_start, .req,
    .app_wdf_wren, .app_wdf_end, .app_wdf_data, .error
  );

endmodule

// File: application_checker.sv
module application_checker import msg_pkg::*, dram_pkg::*; (
  input logic                      bus_clk,
  input logic                      fds_val,
  input msg_word_u                 pc_msg,
  input logic                      pc_msg_empty,
  input logic                      pc_msg_ack,
  input logic                      app_rdy,
  input logic                      app_wdf_rdy,
  input logic                      coeff_high,
  input dram_req_t                 req,
  input logic                      app_wdf_wren,
  input logic                      app_wdf_end,
  input logic [APP_DATA_WIDTH-1:0] app_wdf_data,
  input pixel_pos_t                pos,
  input logic                      heartbeat,
  input logic                      error
);
  int n_errors, n_passes, n_writes, cyc, n_pix, frag;
  logic [3:0] n_dram; // position inside the current DRAM group
  pixel_state_t pstate;
  pixel_pos_t mpos;
  int due_q[$];
  pixel_pos_t pos_q[$];
  logic hb_q[$];
  int fs_q[$]; // cycles at which the sequencer sees a frame start
  logic [2*APP_DATA_WIDTH-1:0] grp;
  logic [2*APP_DATA_WIDTH-1:0] grp_q[$];
  logic last_q[$];
  logic [ADDR_WIDTH-1:0] exp_wr, exp_rd, exp_end;
  logic rd_allowed, replay_wait, err_expect, ch_q, en_q;

  task automatic report_mismatch(input string msg);
    $display("error at %0t: %s", $time, msg);
    n_errors++;
  endtask

  task automatic clear_model();
    n_passes    = 0;
    n_writes    = 0;
    cyc         = 0;
    n_pix       = 0;
    frag        = 0;
    n_dram      = '0;
    pstate      = PIX_STANDBY;
    mpos        = '0;
    exp_wr      = START_ADDR;
    exp_rd      = START_ADDR;
    exp_end     = START_ADDR;
    rd_allowed  = 1'b0;
    replay_wait = 1'b0;
    err_expect  = 1'b0;
    ch_q        = 1'b0;
    en_q        = 1'b0;
    due_q.delete();
    pos_q.delete();
    hb_q.delete();
    fs_q.delete();
    grp_q.delete();
    last_q.delete();
  endtask

  // frame and line rules with the result due three cycles after the acknowledge
  task automatic track_pixel(input msg_word_u w);
    mpos.fds = w.pix.fds;
    n_pix++;
    case (pstate)
      PIX_STANDBY:
        if (!w.pix.fval) begin
          mpos.col   = '0;
          mpos.row   = '0;
          mpos.frame = '0;
          pstate     = PIX_INTERFRAME;
        end
      PIX_INTRALINE:
        if (w.pix.lval) begin
          mpos.col++;
        end else if (w.pix.fval) begin
          mpos.row++;
          pstate = PIX_INTERLINE;
        end else begin
          mpos.frame++;
          pstate = PIX_INTERFRAME;
        end
      PIX_INTERLINE:
        if (w.pix.lval) begin
          mpos.col = '0;
          pstate   = PIX_INTRALINE;
        end
      default:
        if (w.pix.lval) begin
          mpos.col = '0;
          mpos.row = '0;
          pstate   = PIX_INTRALINE;
          fs_q.push_back(cyc + 3); // frame start reaches the sequencer
        end
    endcase
    due_q.push_back(cyc + 3);
    pos_q.push_back(mpos);
    hb_q.push_back(n_pix[3]); // 4-bit heartbeat counter
  endtask

  task automatic collect_fragment(input msg_word_u w);
    grp[frag*XB_SIZE +: XB_SIZE] = w.raw;
    frag++;
    if (frag == MSGS_PER_BURST) begin
      grp_q.push_back(grp);
      last_q.push_back(w.pix.kind == MSG_COEFF_END);
      frag = 0;
    end
  endtask

  always @(posedge bus_clk) begin
    if (fds_val) begin
      clear_model();
    end else begin
      cyc++;
      while (due_q.size() > 0 && due_q[0] == cyc) begin
        if (pos !== pos_q[0])
          report_mismatch($sformatf(
            "pos col %0d row %0d frame %0d fds %h, expected %0d %0d %0d %h",
            pos.col, pos.row, pos.frame, pos.fds,
            pos_q[0].col, pos_q[0].row, pos_q[0].frame, pos_q[0].fds));
        if (heartbeat !== hb_q[0]) report_mismatch($sformatf("heartbeat %b", heartbeat));
        void'(due_q.pop_front());
        void'(pos_q.pop_front());
        void'(hb_q.pop_front());
      end
      // a frame start only restarts a finished read pass
      while (fs_q.size() > 0 && fs_q[0] == cyc) begin
        if (replay_wait) begin
          rd_allowed  = 1'b1;
          replay_wait = 1'b0;
        end
        void'(fs_q.pop_front());
      end
      if (pc_msg_ack && pc_msg_empty) report_mismatch("pc_msg_ack while the PC side is empty");
      if (pc_msg_ack) begin
        if (pc_msg.pix.kind == MSG_PIX && n_dram == 4'd0) track_pixel(pc_msg);
        else begin
          n_dram++;
          collect_fragment(pc_msg);
        end
      end
      if (req.en && !req.read && app_rdy && app_wdf_rdy) begin // write command taken
        if (req.addr !== exp_wr) report_mismatch($sformatf("write addr %0d, expected %0d",
          req.addr, exp_wr));
        exp_wr = exp_wr + ADDR_INC;
        n_writes++;
      end
      if (app_wdf_wren && app_wdf_rdy) begin
        if (grp_q.size() == 0) report_mismatch("data beat with no complete group");
        else if (!app_wdf_end) begin
          if (app_wdf_data !== grp_q[0][0 +: APP_DATA_WIDTH]) report_mismatch("beat 0 data");
        end else begin
          if (app_wdf_data !== grp_q[0][APP_DATA_WIDTH +: APP_DATA_WIDTH])
            report_mismatch("beat 1 data");
          if (last_q[0]) begin
            rd_allowed = 1'b1;
            exp_end = exp_wr;
            exp_rd = START_ADDR;
          end
          void'(grp_q.pop_front());
          void'(last_q.pop_front());
        end
      end
      if (req.en && req.read && !rd_allowed) begin
        report_mismatch("app_en high for a read outside a read pass");
      end else if (req.en && req.read && app_rdy) begin
        if (req.addr !== exp_rd) report_mismatch($sformatf("read addr %0d, expected %0d",
          req.addr, exp_rd));
        exp_rd = exp_rd + ADDR_INC;
        if (exp_rd == exp_end) begin
          exp_rd      = START_ADDR;
          rd_allowed  = 1'b0;
          replay_wait = 1'b1;
          n_passes++;
        end
      end
      if (coeff_high && ch_q && req.en && en_q && req.read)
        report_mismatch("read while throttled");
      if (error !== err_expect) report_mismatch($sformatf("error %b", error));
      if (err_expect && req.en) report_mismatch("app_en high after error");
      if (app_wdf_wren && app_wdf_end && !app_wdf_rdy) err_expect = 1'b1; // beat 1 refused
      ch_q = coeff_high;
      en_q = req.en;
    end
  end

endmodule

// File: application_tb.sv
module application_tb import msg_pkg::*, dram_pkg::*; ();
  logic                      bus_clk = 1'b0;
  logic                      fds_val;
  msg_word_u                 pc_msg;
  logic                      pc_msg_empty, pc_msg_ack;
  logic                      app_rdy, app_wdf_rdy, coeff_high;
  dram_req_t                 req;
  logic                      app_wdf_wren, app_wdf_end;
  logic [APP_DATA_WIDTH-1:0] app_wdf_data;
  pixel_pos_t                pos;
  logic                      heartbeat, error;

  // stimulus table with one PC message per row
  msg_word_u msg_tab [128];
  int        gap_tab [128]; // idle cycles after the word is taken
  logic      ch_tab  [128]; // coeff_high level while the row is active
  int        n_rows, n_phase1;
  int        cycles, limit, other_fails;
  logic      drop_wdf; // controller drops app_wdf_rdy on beat 1

  application #(.HB_CTR_SIZE(4)) application_inst (.*);
  application_checker checker_inst (.*);

  always #4 bus_clk = ~bus_clk;

  // DRAM controller ready model
  always @(negedge bus_clk) begin
    app_rdy = ($urandom % 4) != 0;
    if (app_wdf_wren) app_wdf_rdy = !(drop_wdf && app_wdf_end);
    else app_wdf_rdy = ($urandom % 4) != 0;
  end

  always @(posedge bus_clk) begin
    cycles++;
    if (limit > 0 && cycles >= limit) begin
      $display("timeout: run did not finish within %0d cycles", limit);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  task automatic add_row(input msg_word_u w, input int gap, input logic ch);
    msg_tab[n_rows] = w;
    gap_tab[n_rows] = gap;
    ch_tab[n_rows]  = ch;
    n_rows++;
  endtask

  task automatic add_pixel(input logic fval, input logic lval, input int gap, input logic ch);
    msg_word_u w;
    w          = '0;
    w.pix.fds  = 20'($urandom);
    w.pix.fval = fval;
    w.pix.lval = lval;
    w.pix.kind = MSG_PIX;
    add_row(w, gap, ch);
  endtask

  // sixteen fragments whose first one is never kind 0 so it opens a DRAM group
  task automatic add_group(input logic last, input logic ch);
    msg_word_u w;
    for (int j = 0; j < 16; j++) begin
      w.raw = $urandom;
      if (j == 0) w.raw[1:0] = 2'd2;
      else if (j == 15) w.raw[1:0] = last ? 2'd1 : 2'd3;
      else w.raw[1:0] = ($urandom % 2) ? 2'd0 : 2'd3; // kind 0 inside a group
      add_row(w, int'($urandom % 3), ch);
    end
  endtask

  task automatic apply_row(input int r);
    logic got;
    coeff_high   = ch_tab[r];
    pc_msg       = msg_tab[r];
    pc_msg_empty = 1'b0;
    do begin
      #2 got = pc_msg_ack; // ack is stable in the low phase until the rising edge
      @(negedge bus_clk);
    end while (!got);
    pc_msg_empty = 1'b1;
    repeat (gap_tab[r]) @(negedge bus_clk);
  endtask

  task automatic finish_phase1();
    while (checker_inst.n_passes < 2) @(negedge bus_clk);
    if (checker_inst.n_writes != 3) begin
      $display("expected 3 burst writes before the error phase, saw %0d", checker_inst.n_writes);
      other_fails++;
    end
    repeat (10) @(negedge bus_clk);
    fds_val = 1'b1; // second reset clears the sequencer for the error case
    repeat (8) @(negedge bus_clk);
    fds_val  = 1'b0;
    drop_wdf = 1'b1;
  endtask

  initial begin
    void'($urandom(17));
    fds_val = 1'b1;
    pc_msg = '0;
    pc_msg_empty = 1'b1;
    coeff_high = 1'b0;
    app_rdy = 1'b0;
    app_wdf_rdy = 1'b0;
    drop_wdf = 1'b0;
    add_pixel(1'b1, 1'b1, 0, 1'b0); // ignored in standby
    add_pixel(1'b0, 1'b0, 0, 1'b0);
    for (int k = 0; k < 4; k++) add_pixel(1'b1, 1'b1, k % 2, 1'b0);
    add_pixel(1'b1, 1'b0, 1, 1'b0);
    for (int k = 0; k < 3; k++) add_pixel(1'b1, 1'b1, 0, 1'b0);
    add_pixel(1'b0, 1'b0, 0, 1'b0);
    add_group(1'b0, 1'b0);
    add_group(1'b0, 1'b0);
    add_group(1'b1, 1'b0);
    for (int k = 0; k < 3; k++) add_pixel(1'b0, 1'b0, 3, 1'b1); // throttle the first read pass
    add_pixel(1'b0, 1'b0, 30, 1'b0);
    for (int k = 0; k < 4; k++) add_pixel(1'b1, 1'b1, 0, 1'b0); // second frame starts the replay
    add_pixel(1'b1, 1'b0, 2, 1'b0);
    for (int k = 0; k < 2; k++) add_pixel(1'b1, 1'b1, 0, 1'b0);
    add_pixel(1'b0, 1'b0, 0, 1'b0);
    n_phase1 = n_rows;
    add_group(1'b0, 1'b0);
    limit = n_rows * 40;
    repeat (8) @(negedge bus_clk);
    fds_val = 1'b0;
    for (int r = 0; r < n_rows; r++) begin
      if (r == n_phase1) finish_phase1();
      apply_row(r);
    end
    while (!error) @(negedge bus_clk);
    repeat (10) @(negedge bus_clk); // error must hold
    $display("checker mismatches: %0d, other failures: %0d", checker_inst.n_errors, other_fails);
    if (checker_inst.n_errors == 0 && other_fails == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: application.f
msg_pkg.sv
dram_pkg.sv
msg_fifo.sv
pc_msg_router.sv
pixel_tracker.sv
coeff_packer.sv
dram_sequencer.sv
application.sv
application_checker.sv
application_tb.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary -Wno-fatal --top-module application_tb -f application.f \
		--Mdir obj_dir -o application_sim
	./obj_dir/application_sim | tee sim.log
	@if grep -q '\*\*\* TEST FAILED \*\*\*' sim.log; then \
		echo "simulation failed"; exit 1; \
	fi
	@grep -q '\*\*\* TEST PASSED \*\*\*' sim.log

clean:
	rm -rf obj_dir sim.log
